//--- common/ledmatrix_consts.svh
// --------------------
// widths, timing divisors and driver register values
// timing values count slow_clk cycles
// register data is sized to 8 bits, addresses to 4 bits
// --------------------
`ifndef LEDMATRIX_CONSTS_SVH
`define LEDMATRIX_CONSTS_SVH

// bus and matrix geometry
`define LEDMATRIX_BUS_BITS      16
`define LEDMATRIX_NUM_SEGS      8
`define LEDMATRIX_LEDS_PER_SEG  8

// timing in slow_clk cycles
`define LEDMATRIX_SERIAL_HALF   2
`define LEDMATRIX_SEL_GAP       2
`define LEDMATRIX_PATTERN_TICK  3000
`define LEDMATRIX_DEBOUNCE      16

// driver register addresses
`define LEDMATRIX_REG_DECODE    4'h9
`define LEDMATRIX_REG_INTENSITY 4'ha
`define LEDMATRIX_REG_SCANLIMIT 4'hb
`define LEDMATRIX_REG_SHUTDOWN  4'hc
`define LEDMATRIX_REG_DISPTEST  4'hf

// driver register values
`define LEDMATRIX_DECODE_OFF    8'h00
`define LEDMATRIX_INTENSITY     8'h07
`define LEDMATRIX_SCAN_ALL      8'h07
`define LEDMATRIX_SHUTDOWN_OFF  8'h01
`define LEDMATRIX_DISPTEST_OFF  8'h00

`endif

//--- common/ledmatrix_pkg.sv
// --------------------
// types shared by the led matrix design and its testbench
// widths come from the consts header
// --------------------
`default_nettype none

`include "ledmatrix_consts.svh"

package ledmatrix_pkg;

	// one driver command word, addr in 11:8, data in 7:0
	typedef logic [`LEDMATRIX_BUS_BITS-1:0] bus_word_t;

	// leds of one matrix row
	typedef logic [`LEDMATRIX_LEDS_PER_SEG-1:0] seg_row_t;

	// whole display image
	typedef logic [`LEDMATRIX_NUM_SEGS*`LEDMATRIX_LEDS_PER_SEG-1:0] matrix_bits_t;

	// driver register address
	typedef logic [3:0] digit_addr_t;

	// word sequencer states
	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_LOAD,
		SEQ_SEND,
		SEQ_GAP,
		SEQ_NEXT
	} seq_state_t;

	// serial sender states
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_LOW,
		TX_HIGH,
		TX_DONE
	} tx_state_t;

endpackage

`default_nettype wire

//--- hdl/key_debounce.sv
// --------------------
// key_n is active low and asynchronous
// freeze toggles once per accepted press, release does nothing
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ledmatrix_consts.svh"

module key_debounce (
	input  logic slow_clk,
	input  logic rst,
	input  logic key_n,
	output logic freeze
);

	localparam int CNT_W = $clog2(`LEDMATRIX_DEBOUNCE + 1);

	// two-flop synchroniser, pressed = 1
	logic [1:0] sync_q;
	// accepted key level and its previous value
	logic key_lvl;
	logic key_lvl_q;
	logic [CNT_W-1:0] stable_cnt;

	always_ff @(posedge slow_clk or posedge rst) begin
		if (rst) begin
			sync_q     <= 2'b00;
			key_lvl    <= 1'b0;
			key_lvl_q  <= 1'b0;
			stable_cnt <= '0;
			freeze     <= 1'b0;
		end else begin
			sync_q    <= {sync_q[0], ~key_n};
			key_lvl_q <= key_lvl;
			// restart count on every bounce back to the accepted level
			if (sync_q[1] == key_lvl) begin
				stable_cnt <= '0;
			end else if (stable_cnt == CNT_W'(`LEDMATRIX_DEBOUNCE - 1)) begin
				key_lvl    <= sync_q[1];
				stable_cnt <= '0;
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
			// rising accepted press
			if (key_lvl && !key_lvl_q)
				freeze <= ~freeze;
		end
	end

endmodule

`default_nettype wire

//--- hdl/ledmatrix_top.sv
// --------------------
// single clock domain, rst is asynchronous active high
// led outputs are active low like the board leds
// --------------------
`timescale 1ns/1ps
`default_nettype none

module ledmatrix_top (
	input  logic       slow_clk,
	input  logic       rst,
	input  logic       key_n,
	output logic [1:0] led,
	output logic       mat_dat,
	output logic       mat_sel,
	output logic       mat_clk
);

	import ledmatrix_pkg::*;

	logic         freeze;
	logic         update;
	matrix_bits_t pattern;
	logic         bus_enable;
	logic         bus_ready;
	logic         next_word;
	bus_word_t    bus_data;

	// --------------------
	// key and image source
	key_debounce u_key (
		.slow_clk (slow_clk),
		.rst      (rst),
		.key_n    (key_n),
		.freeze   (freeze)
	);

	pattern_walker u_pattern (
		.slow_clk (slow_clk),
		.rst      (rst),
		.pattern  (pattern)
	);

	// --------------------
	// word sequencer and serial sender
	ledmatrix #(.TRANSPOSE(1'b1)) u_matrix (
		.slow_clk   (slow_clk),
		.rst        (rst),
		.update     (update),
		.pattern    (pattern),
		.bus_ready  (bus_ready),
		.next_word  (next_word),
		.bus_enable (bus_enable),
		.bus_data   (bus_data),
		.mat_sel    (mat_sel)
	);

	serial_tx u_tx (
		.slow_clk   (slow_clk),
		.rst        (rst),
		.bus_enable (bus_enable),
		.bus_data   (bus_data),
		.bus_ready  (bus_ready),
		.next_word  (next_word),
		.mat_clk    (mat_clk),
		.mat_dat    (mat_dat)
	);

	// frames run while not frozen
	assign update = ~freeze;

	// status, low = sender busy / updating
	assign led[0] = bus_ready;
	assign led[1] = ~update;

endmodule

`default_nettype wire

//--- hdl/pattern_walker.sv
// --------------------
// walking-one image, one step per pattern tick
// starts with bit 0 set after reset
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ledmatrix_consts.svh"

module pattern_walker (
	input  logic                        slow_clk,
	input  logic                        rst,
	output ledmatrix_pkg::matrix_bits_t pattern
);

	import ledmatrix_pkg::*;

	localparam int TICK_W = $clog2(`LEDMATRIX_PATTERN_TICK);

	logic [TICK_W-1:0] tick_cnt;
	// one-cycle step enable
	logic step;

	// --------------------
	// tick divider
	always_ff @(posedge slow_clk or posedge rst) begin
		if (rst) begin
			tick_cnt <= '0;
			step     <= 1'b0;
		end else begin
			step <= (tick_cnt == TICK_W'(`LEDMATRIX_PATTERN_TICK - 1));
			if (tick_cnt == TICK_W'(`LEDMATRIX_PATTERN_TICK - 1))
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// --------------------
	// rotate left, top bit wraps to bit 0
	always_ff @(posedge slow_clk or posedge rst) begin
		if (rst)
			pattern <= matrix_bits_t'(1);
		else if (step)
			pattern <= {pattern[$bits(matrix_bits_t)-2:0], pattern[$bits(matrix_bits_t)-1]};
	end

endmodule

`default_nettype wire

//--- ledmatrix/ledmatrix.sv
// --------------------
// five init words once after reset, then frames of eight row words
// image is sampled at frame start only
// update low holds off the next frame, never the current one
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ledmatrix_consts.svh"

module ledmatrix #(
	parameter bit TRANSPOSE = 1'b1
) (
	input  logic                        slow_clk,
	input  logic                        rst,
	input  logic                        update,
	input  ledmatrix_pkg::matrix_bits_t pattern,
	input  logic                        bus_ready,
	input  logic                        next_word,
	output logic                        bus_enable,
	output ledmatrix_pkg::bus_word_t    bus_data,
	output logic                        mat_sel
);

	import ledmatrix_pkg::*;

	localparam int NUM_INIT  = 5;
	localparam int LAST_WORD = NUM_INIT + `LEDMATRIX_NUM_SEGS - 1;

	seq_state_t   state;
	// 0..4 init words, 5..12 digit words
	logic [3:0]   widx;
	logic         init_done;
	logic [3:0]   gap_cnt;
	matrix_bits_t frame_bits;

	logic         start_frame;
	logic [2:0]   row_idx;
	digit_addr_t  digit;
	seg_row_t     row_bits;
	bus_word_t    load_word;

	assign start_frame = (state == SEQ_IDLE) && init_done && update;

	// --------------------
	// word selection and row mapping
	always_comb begin
		row_idx = 3'(widx - 4'd5);
		digit   = digit_addr_t'(widx - 4'd4);
		for (int j = 0; j < `LEDMATRIX_LEDS_PER_SEG; j++) begin
			// column mapping, one bit out of each byte
			if (TRANSPOSE)
				row_bits[j] = frame_bits[`LEDMATRIX_NUM_SEGS * j + row_idx];
			else
				row_bits[j] = frame_bits[`LEDMATRIX_LEDS_PER_SEG * row_idx + j];
		end
		case (widx)
			4'd0:    load_word = {4'h0, `LEDMATRIX_REG_DECODE, `LEDMATRIX_DECODE_OFF};
			4'd1:    load_word = {4'h0, `LEDMATRIX_REG_INTENSITY, `LEDMATRIX_INTENSITY};
			4'd2:    load_word = {4'h0, `LEDMATRIX_REG_SCANLIMIT, `LEDMATRIX_SCAN_ALL};
			4'd3:    load_word = {4'h0, `LEDMATRIX_REG_SHUTDOWN, `LEDMATRIX_SHUTDOWN_OFF};
			4'd4:    load_word = {4'h0, `LEDMATRIX_REG_DISPTEST, `LEDMATRIX_DISPTEST_OFF};
			// digit registers 1..8
			default: load_word = {4'h0, digit, row_bits};
		endcase
	end

	// --------------------
	// sequencer fsm
	always_ff @(posedge slow_clk or posedge rst) begin
		if (rst) begin
			state      <= SEQ_IDLE;
			widx       <= '0;
			init_done  <= 1'b0;
			gap_cnt    <= '0;
			bus_enable <= 1'b0;
			mat_sel    <= 1'b1;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (!init_done) begin
						widx  <= '0;
						state <= SEQ_LOAD;
					end else if (update) begin
						widx  <= 4'(NUM_INIT);
						state <= SEQ_LOAD;
					end
				end
				// wait for the sender, then select low with enable
				SEQ_LOAD: begin
					if (bus_ready) begin
						bus_enable <= 1'b1;
						mat_sel    <= 1'b0;
						state      <= SEQ_SEND;
					end
				end
				SEQ_SEND: begin
					if (next_word) begin
						// one word per transfer
						bus_enable <= 1'b0;
					end else if (!bus_enable && bus_ready) begin
						// rising select latches the word
						mat_sel <= 1'b1;
						gap_cnt <= '0;
						state   <= SEQ_GAP;
					end
				end
				SEQ_GAP: begin
					if (gap_cnt == 4'(`LEDMATRIX_SEL_GAP - 1))
						state <= SEQ_NEXT;
					else
						gap_cnt <= gap_cnt + 1'b1;
				end
				SEQ_NEXT: begin
					if (widx == 4'(NUM_INIT - 1)) begin
						init_done <= 1'b1;
						state     <= SEQ_IDLE;
					end else if (widx == 4'(LAST_WORD)) begin
						// frame done, idle decides on the next one
						state <= SEQ_IDLE;
					end else begin
						widx  <= widx + 1'b1;
						state <= SEQ_LOAD;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

	// --------------------
	// payload registers
	always_ff @(posedge slow_clk) begin
		// one consistent image per frame
		if (start_frame)
			frame_bits <= pattern;
		if (state == SEQ_LOAD)
			bus_data <= load_word;
	end

endmodule

`default_nettype wire

//--- ledmatrix_top.f
+incdir+common
common/ledmatrix_pkg.sv
hdl/key_debounce.sv
hdl/pattern_walker.sv
serial_tx/serial_tx.sv
ledmatrix/ledmatrix.sv
hdl/ledmatrix_top.sv
testbench/ledmatrix_props.sv
testbench/ledmatrix_tb.sv

//--- serial_tx/serial_tx.sv
// --------------------
// msb first, data changes while mat_clk is low
// bus_data is taken in the idle cycle that sees bus_enable
// clock and data lines rest low
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ledmatrix_consts.svh"

module serial_tx (
	input  logic                     slow_clk,
	input  logic                     rst,
	input  logic                     bus_enable,
	input  ledmatrix_pkg::bus_word_t bus_data,
	output logic                     bus_ready,
	output logic                     next_word,
	output logic                     mat_clk,
	output logic                     mat_dat
);

	import ledmatrix_pkg::*;

	localparam int HALF_W = $clog2(`LEDMATRIX_SERIAL_HALF + 1);
	localparam int BIT_W  = $clog2(`LEDMATRIX_BUS_BITS);

	tx_state_t         state;
	logic [HALF_W-1:0] half_cnt;
	logic [BIT_W-1:0]  bit_cnt;
	bus_word_t         shift_q;

	logic accept;
	logic half_done;
	logic last_bit;

	assign bus_ready = (state == TX_IDLE);
	assign accept    = bus_ready && bus_enable;
	assign half_done = (half_cnt == HALF_W'(`LEDMATRIX_SERIAL_HALF - 1));
	assign last_bit  = (bit_cnt == BIT_W'(`LEDMATRIX_BUS_BITS - 1));

	// --------------------
	// line outputs
	assign mat_clk = (state == TX_HIGH);
	assign mat_dat = (state == TX_LOW || state == TX_HIGH) ? shift_q[$bits(bus_word_t)-1] : 1'b0;

	// --------------------
	// control fsm
	always_ff @(posedge slow_clk or posedge rst) begin
		if (rst) begin
			state     <= TX_IDLE;
			half_cnt  <= '0;
			bit_cnt   <= '0;
			next_word <= 1'b0;
		end else begin
			// pulse only in the cycle after acceptance
			next_word <= 1'b0;
			case (state)
				TX_IDLE: begin
					if (accept) begin
						next_word <= 1'b1;
						half_cnt  <= '0;
						bit_cnt   <= '0;
						state     <= TX_LOW;
					end
				end
				TX_LOW: begin
					if (half_done) begin
						half_cnt <= '0;
						state    <= TX_HIGH;
					end else begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				TX_HIGH: begin
					if (half_done) begin
						half_cnt <= '0;
						if (last_bit) begin
							state <= TX_DONE;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							state   <= TX_LOW;
						end
					end else begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				// one quiet cycle before ready again
				TX_DONE: state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	// --------------------
	// shift register, moves on at the end of each high half
	always_ff @(posedge slow_clk) begin
		if (accept)
			shift_q <= bus_data;
		else if (state == TX_HIGH && half_done)
			shift_q <= shift_q << 1;
	end

endmodule

`default_nettype wire

//--- testbench/ledmatrix_golden.txt
# init <word hex> : expected init words in send order
# row <digit> <data hex> : first frame after reset, image bit 0 set
# map <bit stride> <digit stride> : image bit = bit stride * j + digit stride * (digit - 1)
# key <test name> <press|release> <bounce toggles>
init 0900
init 0a07
init 0b07
init 0c01
init 0f00
map 8 1
row 1 01
row 2 00
row 3 00
row 4 00
row 5 00
row 6 00
row 7 00
row 8 00
key freeze press 9
key freeze_release release 5
key resume press 11
key resume_release release 7

//--- testbench/ledmatrix_props.sv
// --------------------
// serial bus properties, bound into ledmatrix_top
// all of them are off while rst is high
// --------------------
`timescale 1ns/1ps
`default_nettype none

module ledmatrix_props (
	input logic slow_clk,
	input logic rst,
	input logic mat_sel,
	input logic mat_clk,
	input logic mat_dat,
	input logic next_word,
	input logic bus_enable
);

	// serial clock only runs inside a selected word
	sel_clk_idle: assert property (@(posedge slow_clk) disable iff (rst)
		mat_sel |-> !mat_clk)
		else $error("mat_clk high while mat_sel is high");

	// single cycle strobe
	next_word_pulse: assert property (@(posedge slow_clk) disable iff (rst)
		next_word |=> !next_word)
		else $error("next_word longer than one cycle");

	// one word per transfer
	enable_drop: assert property (@(posedge slow_clk) disable iff (rst)
		next_word |=> $fell(bus_enable))
		else $error("bus_enable did not fall after next_word");

	// data settles while the clock is low
	dat_stable: assert property (@(posedge slow_clk) disable iff (rst)
		(mat_clk && $past(mat_clk)) |-> $stable(mat_dat))
		else $error("mat_dat changed while mat_clk high");

endmodule

bind ledmatrix_top ledmatrix_props u_props (
	.slow_clk   (slow_clk),
	.rst        (rst),
	.mat_sel    (mat_sel),
	.mat_clk    (mat_clk),
	.mat_dat    (mat_dat),
	.next_word  (next_word),
	.bus_enable (bus_enable)
);

`default_nettype wire

//--- testbench/ledmatrix_tb.sv
// --------------------
// golden file is read from testbench/ under the project root
// only the default TRANSPOSE mapping is exercised
// waits give up through a watchdog that ends the run
// --------------------
`timescale 1ns/1ps
`default_nettype none

`include "ledmatrix_consts.svh"

module ledmatrix_tb;

	import ledmatrix_pkg::*;

	// a bit over one frame of eight words
	localparam int FRAME_CYC = 700;

	logic       slow_clk;
	logic       rst;
	logic       key_n;
	logic [1:0] led;
	logic       mat_dat;
	logic       mat_sel;
	logic       mat_clk;

	// --------------------
	// golden data
	bus_word_t init_words [0:4];
	seg_row_t  first_rows [0:7];
	int        map_bit;
	int        map_dig;
	string     key_name [0:7];
	logic      key_press [0:7];
	int        key_bounce [0:7];
	int        num_keys;

	int          checks;
	int          errors;
	int          tests;
	int          failed;
	logic [31:0] rng;
	int          epoch;
	logic        stall;
	string       stall_msg;

	// monitor state, word_cnt and bits_now are read by the main flow
	int           word_cnt;
	int           bits_now;
	int           wc;
	int           bc;
	int           mon_epoch;
	logic         have_prev;
	logic         prev_clk;
	logic         prev_sel;
	bus_word_t    shift_w;
	matrix_bits_t img;
	matrix_bits_t last_img;

	ledmatrix_top DUT (
		.slow_clk (slow_clk),
		.rst      (rst),
		.key_n    (key_n),
		.led      (led),
		.mat_dat  (mat_dat),
		.mat_sel  (mat_sel),
		.mat_clk  (mat_clk)
	);

	initial slow_clk = 1'b0;
	always #10 slow_clk = ~slow_clk;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// --------------------
	// compare tasks
	task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_image(input string name, input matrix_bits_t exp,
		input matrix_bits_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("Mismatch %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// hands over to the watchdog, never returns
	task automatic abort(input string msg);
		stall_msg = msg;
		stall = 1'b1;
		forever @(negedge slow_clk);
	endtask

	always @(posedge stall) begin
		$display("%s", stall_msg);
		$display("CHECKS FAILED");
		$finish;
	end

	task automatic load_golden();
		int    fd;
		int    c;
		int    n_init;
		int    idx;
		int    val;
		int    cnt;
		string kw;
		string nm;
		string dir;
		fd = $fopen("testbench/ledmatrix_golden.txt", "r");
		if (fd == 0)
			abort("cannot open testbench/ledmatrix_golden.txt");
		n_init = 0;
		num_keys = 0;
		while ($fscanf(fd, "%s", kw) == 1) begin
			if (kw == "init") begin
				cnt = $fscanf(fd, "%h", val);
				if (cnt != 1)
					abort("golden file has an init line without a word");
				init_words[n_init] = bus_word_t'(val);
				n_init++;
			end else if (kw == "row") begin
				cnt = $fscanf(fd, "%d %h", idx, val);
				if (cnt != 2)
					abort("golden file has an incomplete row line");
				first_rows[idx-1] = seg_row_t'(val);
			end else if (kw == "map") begin
				cnt = $fscanf(fd, "%d %d", map_bit, map_dig);
				if (cnt != 2)
					abort("golden file has an incomplete map line");
			end else if (kw == "key") begin
				cnt = $fscanf(fd, "%s %s %d", nm, dir, val);
				if (cnt != 3)
					abort("golden file has an incomplete key line");
				key_name[num_keys] = nm;
				key_press[num_keys] = (dir == "press");
				key_bounce[num_keys] = val;
				num_keys++;
			end else begin
				// comment, skip rest of line
				c = $fgetc(fd);
				while (c != 10 && c != -1)
					c = $fgetc(fd);
			end
		end
		$fclose(fd);
		if (n_init != 5)
			abort("golden file does not hold five init words");
	endtask

	// --------------------
	// word capture, sampled on the falling edge where lines are settled
	task automatic word_done();
		int pos;
		pos = (wc - 5) % 8;
		check_bit("word_length", 1'b1, bc == `LEDMATRIX_BUS_BITS);
		if (wc < 5) begin
			check_word("init", init_words[wc], shift_w);
		end else begin
			check_word("row_address", {4'h0, digit_addr_t'(pos + 1), 8'h00},
				shift_w & 16'h0f00);
			if ((wc - 5) / 8 == 0)
				check_word("first_frame_row", {4'h0, digit_addr_t'(pos + 1), first_rows[pos]},
					shift_w);
			for (int j = 0; j < `LEDMATRIX_LEDS_PER_SEG; j++)
				img[map_bit * j + map_dig * pos] = shift_w[j];
			if (pos == 7) begin
				check_bit("image_one_hot", 1'b1, $onehot(img));
				// same image or one step on
				if (have_prev && mon_epoch == epoch && img !== last_img)
					check_image("image_step", {last_img[62:0], last_img[63]}, img);
				have_prev = 1'b1;
				mon_epoch = epoch;
				last_img = img;
				img = '0;
			end
		end
	endtask

	always @(negedge slow_clk) begin : capture
		if (rst) begin
			wc = 0;
			bc = 0;
			have_prev = 1'b0;
			img = '0;
			prev_clk = 1'b0;
			prev_sel = 1'b1;
		end else begin
			if (mat_clk && !prev_clk && !mat_sel) begin
				shift_w = {shift_w[$bits(bus_word_t)-2:0], mat_dat};
				bc++;
			end
			// word ends on rising select
			if (mat_sel && !prev_sel) begin
				word_done();
				wc++;
				bc = 0;
			end
			prev_clk = mat_clk;
			prev_sel = mat_sel;
		end
		word_cnt <= wc;
		bits_now <= bc;
	end

	// --------------------
	// counted waits
	task automatic wait_words(input int target, input int limit, input string what);
		int n;
		n = 0;
		while (word_cnt < target) begin
			if (n == limit)
				abort({"timeout waiting for words of ", what});
			@(negedge slow_clk);
			n++;
		end
	endtask

	task automatic wait_led1(input logic exp, input int limit, input string what);
		int n;
		n = 0;
		while (led[1] !== exp) begin
			if (n == limit)
				abort({"timeout waiting for the freeze status in ", what});
			@(negedge slow_clk);
			n++;
		end
	endtask

	task automatic wait_quiet(input int run, input int limit);
		int n;
		int q;
		n = 0;
		q = 0;
		while (q < run) begin
			if (n == limit)
				abort("serial bus still active long after freeze");
			@(negedge slow_clk);
			q = mat_sel ? q + 1 : 0;
			n++;
		end
	endtask

	task automatic wait_mid_word(input int limit);
		int n;
		n = 0;
		while (mat_sel || bits_now < 5) begin
			if (n == limit)
				abort("timeout waiting for a word in progress");
			@(negedge slow_clk);
			n++;
		end
	endtask

	// bounce burst kept shorter than the debounce count
	task automatic apply_key(input logic press, input int bounces);
		logic lvl;
		int   spent;
		int   hold;
		lvl = key_n;
		spent = 0;
		for (int i = 0; i < bounces; i++) begin
			rng = xorshift(rng);
			hold = 1 + int'(rng[0]);
			if (spent + hold < `LEDMATRIX_DEBOUNCE - 1) begin
				lvl = ~lvl;
				key_n <= lvl;
				repeat (hold) @(negedge slow_clk);
				spent += hold;
			end
		end
		key_n <= ~press;
	endtask

	task automatic end_test(input string name, input int err0);
		tests++;
		if (errors == err0) begin
			$display("test %-16s ok", name);
		end else begin
			failed++;
			$display("test %-16s failed with %0d errors", name, errors - err0);
		end
	endtask

	// --------------------
	// main flow
	initial begin : run
		int   err0;
		int   start;
		int   nb;
		logic exp_freeze;
		logic l0_low;
		logic l1_wrong;
		rst = 1'b1;
		key_n = 1'b1;
		checks = 0;
		errors = 0;
		tests = 0;
		failed = 0;
		epoch = 0;
		stall = 1'b0;
		rng = 32'h0b22_0e1a;
		load_golden();
		repeat (5) @(negedge slow_clk);
		err0 = errors;
		check_bit("reset_mat_sel", 1'b1, mat_sel);
		check_bit("reset_mat_clk", 1'b0, mat_clk);
		check_bit("reset_mat_dat", 1'b0, mat_dat);
		check_bit("reset_led1", 1'b0, led[1]);
		end_test("reset_values", err0);
		rst <= 1'b0;

		err0 = errors;
		wait_words(5, 2 * FRAME_CYC, "init");
		end_test("init", err0);
		err0 = errors;
		wait_words(13, 2 * FRAME_CYC, "first frame");
		end_test("first_frame", err0);
		// enough frames to see the pattern step
		err0 = errors;
		wait_words(13 + 64, 9 * FRAME_CYC, "frames");
		end_test("frames", err0);

		exp_freeze = 1'b0;
		for (int k = 0; k < num_keys; k++) begin
			err0 = errors;
			apply_key(key_press[k], key_bounce[k]);
			if (key_press[k]) begin
				exp_freeze = ~exp_freeze;
				wait_led1(exp_freeze, 100, key_name[k]);
				// frames across the toggle are not compared
				epoch <= epoch + 1;
				start = word_cnt;
				if (exp_freeze) begin
					wait_quiet(150, 2 * FRAME_CYC);
					check_bit({key_name[k], "_words"}, 1'b1, word_cnt - start <= 8);
					check_bit({key_name[k], "_boundary"}, 1'b1, (word_cnt - 5) % 8 == 0);
					start = word_cnt;
					l0_low = 1'b0;
					l1_wrong = 1'b0;
					repeat (4 * FRAME_CYC) begin
						@(negedge slow_clk);
						l0_low |= ~led[0];
						l1_wrong |= ~led[1];
					end
					check_bit({key_name[k], "_quiet"}, 1'b1, word_cnt == start);
					check_bit({key_name[k], "_led0"}, 1'b0, l0_low);
					check_bit({key_name[k], "_led1_held"}, 1'b0, l1_wrong);
				end else begin
					// next frame boundary, then two whole frames
					nb = 5 + ((start - 5 + 7) / 8) * 8;
					wait_words(nb + 16, 4 * FRAME_CYC, key_name[k]);
				end
			end else begin
				start = word_cnt;
				repeat (4 * `LEDMATRIX_DEBOUNCE) @(negedge slow_clk);
				check_bit({key_name[k], "_led1"}, exp_freeze, led[1]);
				if (exp_freeze)
					check_bit({key_name[k], "_quiet"}, 1'b1, word_cnt == start);
			end
			end_test(key_name[k], err0);
		end

		// reset in the middle of a word
		err0 = errors;
		wait_mid_word(2 * FRAME_CYC);
		rst <= 1'b1;
		@(negedge slow_clk);
		check_bit("rst_mat_sel", 1'b1, mat_sel);
		check_bit("rst_mat_clk", 1'b0, mat_clk);
		check_bit("rst_mat_dat", 1'b0, mat_dat);
		repeat (4) @(negedge slow_clk);
		rst <= 1'b0;
		wait_words(13, 2 * FRAME_CYC, "init after reset");
		end_test("reset_mid_frame", err0);

		$display("%0d tests, %0d failing, %0d checks, %0d errors", tests, failed, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
